//--- sim.f
+incdir+src
src/rename_pkg.sv
src/rename_if.sv
src/inst_queue.sv
src/free_list.sv
src/rename_table.sv
src/dispatcher.sv
src/dispatch_out.sv
src/rename_dispatch_top.sv
sim/rename_dispatch_properties.sv
sim/rename_dispatch_checker.sv
sim/rename_dispatch_tb.sv

//--- sim/rename_dispatch_checker.sv
// Model renames in program order at out_valid; exact as long as the free list never runs short
`timescale 1ns/1ns
`include "rename_params.svh"

module rename_dispatch_checker
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic            in_ready,
    input  pc_t             in_pc [`SS],
    input  arch_reg_t       in_rs1 [`SS],
    input  arch_reg_t       in_rs2 [`SS],
    input  arch_reg_t       in_rd [`SS],
    input  logic            in_imm1 [`SS],
    input  logic            in_imm2 [`SS],
    input  logic            wb_valid,
    input  preg_t           wb_preg,
    input  logic            free_valid,
    input  preg_t           free_preg,
    input  logic            out_valid,
    input  rob_id_t         out_rob_id [`SS],
    input  pc_t             out_pc [`SS],
    input  arch_reg_t       out_rd [`SS],
    input  preg_t           out_rd_preg [`SS],
    input  preg_t           out_rs1_preg [`SS],
    input  preg_t           out_rs2_preg [`SS],
    input  logic            out_rs1_ready [`SS],
    input  logic            out_rs2_ready [`SS],
    input  rob_id_t         out_rs1_rob [`SS],
    input  rob_id_t         out_rs2_rob [`SS],
    input  logic [8*16-1:0] test_name,
    output int              err_cnt,
    output int              seen_cnt
);
    typedef struct packed {
        pc_t       pc;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      imm1;
        logic      imm2;
    } slot_t;
    typedef slot_t [`SS-1:0] bundle_t;

    // Bundles pushed but not yet seen at the output, oldest first
    bundle_t pend [$];
    string   names [$];
    bundle_t new_b;

    // Reference state
    preg_t   rat [`ARCH_REGS];
    logic    busy [`PREG_COUNT];
    rob_id_t prod [`PREG_COUNT];
    preg_t   free_q [$];
    rob_id_t rob_cnt;

    task automatic expect_eq(input string name, input int slot, input string field,
                             input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            err_cnt++;
            $display("mismatch %0s slot %0d %0s: expected %0d, actual %0d",
                     name, slot, field, exp_v, act_v);
        end
    endtask

    // Slots rename one after another, so slot 1 sees slot 0's new mapping
    task automatic check_bundle();
        bundle_t b;
        string   name;
        preg_t   src1;
        preg_t   src2;
        preg_t   dst;
        rob_id_t rid;
        b    = pend.pop_front();
        name = names.pop_front();
        for (int i = 0; i < `SS; i++) begin
            rid  = rob_cnt + rob_id_t'(i);
            src1 = rat[b[i].rs1];
            src2 = rat[b[i].rs2];
            dst  = '0;
            if (b[i].rd != '0)
                dst = free_q.pop_front();
            expect_eq(name, i, "rob_id", int'(rid), int'(out_rob_id[i]));
            expect_eq(name, i, "pc", int'(b[i].pc), int'(out_pc[i]));
            expect_eq(name, i, "rd", int'(b[i].rd), int'(out_rd[i]));
            expect_eq(name, i, "rd_preg", int'(dst), int'(out_rd_preg[i]));
            expect_eq(name, i, "rs1_preg", int'(src1), int'(out_rs1_preg[i]));
            expect_eq(name, i, "rs2_preg", int'(src2), int'(out_rs2_preg[i]));
            expect_eq(name, i, "rs1_ready", int'(b[i].imm1 || !busy[src1]),
                      int'(out_rs1_ready[i]));
            expect_eq(name, i, "rs2_ready", int'(b[i].imm2 || !busy[src2]),
                      int'(out_rs2_ready[i]));
            // Producer tag only means something while the preg is pending
            if (busy[src1])
                expect_eq(name, i, "rs1_rob", int'(prod[src1]), int'(out_rs1_rob[i]));
            if (busy[src2])
                expect_eq(name, i, "rs2_rob", int'(prod[src2]), int'(out_rs2_rob[i]));
            if (b[i].rd != '0) begin
                rat[b[i].rd] = dst;
                busy[dst]    = 1'b1;
                prod[dst]    = rid;
            end
        end
        rob_cnt = rob_cnt + rob_id_t'(`SS);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ARCH_REGS; r++)
                rat[r] = preg_t'(r);
            for (int p = 0; p < `PREG_COUNT; p++) begin
                busy[p] = 1'b0;
                prod[p] = '0;
            end
            free_q.delete();
            for (int p = `ARCH_REGS; p < `PREG_COUNT; p++)
                free_q.push_back(preg_t'(p));
            pend.delete();
            names.delete();
            rob_cnt  = '0;
            err_cnt  = 0;
            seen_cnt = 0;
        end else begin
            // Output first, so a push at the same edge cannot be taken for it
            if (out_valid) begin
                if (pend.size() == 0) begin
                    err_cnt++;
                    $display("error: out_valid rose with no bundle outstanding");
                end else begin
                    check_bundle();
                end
                seen_cnt++;
            end
            if (in_valid && in_ready) begin
                for (int i = 0; i < `SS; i++) begin
                    new_b[i].pc   = in_pc[i];
                    new_b[i].rs1  = in_rs1[i];
                    new_b[i].rs2  = in_rs2[i];
                    new_b[i].rd   = in_rd[i];
                    new_b[i].imm1 = in_imm1[i];
                    new_b[i].imm2 = in_imm2[i];
                end
                pend.push_back(new_b);
                names.push_back($sformatf("%0s", test_name));
            end
            // Writebacks and retires after this edge's dispatch check
            if (wb_valid)
                busy[wb_preg] = 1'b0;
            if (free_valid)
                free_q.push_back(free_preg);
        end
    end

    // Queue occupancy is pending bundles minus the one leaving this cycle
    always @(negedge clk) begin
        if (!rst)
            expect_eq("in_ready_chk", 0, "in_ready",
                      int'((int'(pend.size()) - int'(out_valid)) < `IQ_DEPTH),
                      int'(in_ready));
    end

endmodule

//--- sim/rename_dispatch_properties.sv
// Bound into every rename_dispatch_top; samples on the rising clock edge
`timescale 1ns/1ns
`include "rename_params.svh"

module rename_dispatch_properties
    import rename_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      out_valid,
    input logic      rs_full,
    input fl_count_t fl_count
);
    // Failed assertions, read by the testbench at the end
    int fail_cnt = 0;

    // Covers the reset cycles and the first one after release
    reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid high during or right after reset");
        end

    // A cycle held back by rs_full shows no entry in the cycle after it
    full_blocks_dispatch: assert property (@(posedge clk) disable iff (rst)
        rs_full |=> !out_valid)
        else begin
            fail_cnt++;
            $error("bundle dispatched while rs_full was high");
        end

    // Popping past an empty free list wraps the count above the register total
    pop_within_count: assert property (@(posedge clk) disable iff (rst)
        fl_count <= fl_count_t'(`PREG_COUNT))
        else begin
            fail_cnt++;
            $error("free list popped more registers than it holds");
        end

endmodule

bind rename_dispatch_top rename_dispatch_properties props (
    .clk, .rst, .out_valid, .rs_full, .fl_count
);

//--- sim/rename_dispatch_tb.sv
// Reads sim/rename_stim.txt from the project root; writebacks and frees wait until the pipe drains
`timescale 1ns/1ns
`include "rename_params.svh"

module rename_dispatch_tb
    import rename_pkg::*;
();
    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    pc_t       in_pc [`SS];
    arch_reg_t in_rs1 [`SS];
    arch_reg_t in_rs2 [`SS];
    arch_reg_t in_rd [`SS];
    logic      in_imm1 [`SS];
    logic      in_imm2 [`SS];
    logic      rs_full;
    logic      wb_valid;
    preg_t     wb_preg;
    logic      free_valid;
    preg_t     free_preg;
    logic      out_valid;
    rob_id_t   out_rob_id [`SS];
    pc_t       out_pc [`SS];
    arch_reg_t out_rd [`SS];
    preg_t     out_rd_preg [`SS];
    preg_t     out_rs1_preg [`SS];
    preg_t     out_rs2_preg [`SS];
    logic      out_rs1_ready [`SS];
    logic      out_rs2_ready [`SS];
    rob_id_t   out_rs1_rob [`SS];
    rob_id_t   out_rs2_rob [`SS];

    // Test name travels with each pushed bundle
    logic [8*16-1:0] test_name;
    logic [8*16-1:0] line_name;
    // Bundle fields of the current line, six per slot
    int fld [12];
    int err_cnt;
    int seen_cnt;
    int push_cnt;
    int other_err;

    rename_dispatch_top dut (.*);

    rename_dispatch_checker chk (.*);

    always #10 clk = ~clk;

    // Block until every pushed bundle has come out
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (seen_cnt != push_cnt && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (seen_cnt != push_cnt) begin
            $display("timeout: only %0d of %0d pushed bundles came out", seen_cnt, push_cnt);
            other_err++;
        end
    endtask

    // Wait for room, then hold in_valid across one rising edge
    task automatic push_bundle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low before bundle %0s", line_name);
            other_err++;
        end else begin
            for (int i = 0; i < `SS; i++) begin
                in_pc[i]   = pc_t'(fld[6*i]);
                in_rs1[i]  = arch_reg_t'(fld[6*i+1]);
                in_rs2[i]  = arch_reg_t'(fld[6*i+2]);
                in_rd[i]   = arch_reg_t'(fld[6*i+3]);
                in_imm1[i] = (fld[6*i+4] != 0);
                in_imm2[i] = (fld[6*i+5] != 0);
            end
            test_name = line_name;
            in_valid  = 1'b1;
            @(negedge clk);
            in_valid  = 1'b0;
            push_cnt++;
        end
    endtask

    // One stimulus line: name, command, arguments
    task automatic run_line(input string line);
        string cmd;
        int    arg;
        int    gap;
        int    n;
        n = $sscanf(line, "%s %s %d", line_name, cmd, arg);
        if (cmd == "bundle") begin
            n = $sscanf(line, "%s %s %h %d %d %d %d %d %h %d %d %d %d %d",
                        line_name, cmd, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                        fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
            if (n != 14) begin
                $display("error: bundle line %0s has %0d fields instead of 14", line_name, n);
                other_err++;
            end else begin
                push_bundle();
            end
        end else if (cmd == "wb") begin
            wait_for_drain();
            @(negedge clk);
            wb_valid = 1'b1;
            wb_preg  = preg_t'(arg);
            @(negedge clk);
            wb_valid = 1'b0;
        end else if (cmd == "free") begin
            wait_for_drain();
            @(negedge clk);
            free_valid = 1'b1;
            free_preg  = preg_t'(arg);
            @(negedge clk);
            free_valid = 1'b0;
        end else if (cmd == "full") begin
            @(negedge clk);
            rs_full = (arg != 0);
        end else if (cmd == "idle") begin
            // Random stretch on top of the minimum gap
            gap = arg + int'($urandom % (arg + 1));
            repeat (gap) @(negedge clk);
        end else begin
            $display("error: unknown command %0s on stimulus line %0s", cmd, line_name);
            other_err++;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        rs_full    = 1'b0;
        wb_valid   = 1'b0;
        wb_preg    = '0;
        free_valid = 1'b0;
        free_preg  = '0;
        test_name  = '0;
        push_cnt   = 0;
        other_err  = 0;
        for (int i = 0; i < `SS; i++) begin
            in_pc[i]   = '0;
            in_rs1[i]  = '0;
            in_rs2[i]  = '0;
            in_rd[i]   = '0;
            in_imm1[i] = 1'b0;
            in_imm2[i] = 1'b0;
        end
        void'($urandom(32'h18885048));
        repeat (10) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/rename_stim.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open sim/rename_stim.txt");
            other_err++;
        end else begin
            // Stop at the first timeout or malformed line
            while (!$feof(fd) && other_err == 0) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#")
                    run_line(line);
            end
            $fclose(fd);
            if (other_err == 0)
                wait_for_drain();
        end

        $display("errors: %0d mismatches, %0d assertion failures, %0d other",
                 err_cnt, dut.props.fail_cnt, other_err);
        if (err_cnt == 0 && dut.props.fail_cnt == 0 && other_err == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/rename_stim.txt
# name cmd; bundle: slot 0 then slot 1, each pc(hex) rs1 rs2 rd imm1 imm2
# wb and free take a preg, full takes a level 0 or 1, idle a minimum gap in cycles
ident bundle 00001000 1 2 3 0 0 00001004 4 5 6 0 1
fwd bundle 00001008 3 7 8 0 0 0000100c 8 3 9 0 0
x0_dst bundle 00001010 8 9 0 0 0 00001014 0 0 10 0 0
gap1 idle 3
wb32 wb 32
ready bundle 00001018 3 8 11 0 0 0000101c 9 12 12 1 1
full_on full 1
bp1 bundle 00001020 1 2 13 0 0 00001024 13 1 14 0 0
bp2 bundle 00001028 14 0 15 0 1 0000102c 2 15 16 0 0
bp3 bundle 00001030 16 3 17 0 0 00001034 17 17 17 0 0
bp4 bundle 00001038 4 5 18 1 0 0000103c 18 4 19 0 0
hold idle 4
full_off full 0
gap2 idle 2
free3 free 3
free6 free 6
wb34 wb 34
fl1 bundle 00001040 8 20 20 0 0 00001044 20 21 21 0 0
fl2 bundle 00001048 21 1 22 0 1 0000104c 22 22 23 0 0
fl3 bundle 00001050 23 2 24 0 0 00001054 24 23 25 1 0
fl4 bundle 00001058 25 24 26 0 0 0000105c 26 0 27 0 0
fl5 bundle 00001060 27 26 28 0 0 00001064 28 27 29 0 0
fl6 bundle 00001068 29 0 30 0 1 0000106c 30 29 31 0 0
fl7 bundle 00001070 31 30 1 0 0 00001074 1 31 2 0 0
fl8 bundle 00001078 2 1 3 0 0 0000107c 3 2 4 0 0
fl9 bundle 00001080 4 3 5 0 0 00001084 5 4 6 0 0
fl10 bundle 00001088 0 0 0 0 0 0000108c 0 5 7 0 0
tail idle 2

//--- src/dispatch_out.sv
// ROB fullness is not tracked; ids simply wrap modulo ROB_DEPTH
`timescale 1ns/1ns
`include "rename_params.svh"

module dispatch_out
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch,
    input  pc_t       ent_pc [`SS],
    input  arch_reg_t ent_rd [`SS],
    input  preg_t     ent_rd_preg [`SS],
    input  preg_t     ent_rs1_preg [`SS],
    input  preg_t     ent_rs2_preg [`SS],
    input  logic      ent_rs1_ready [`SS],
    input  logic      ent_rs2_ready [`SS],
    input  rob_id_t   ent_rs1_rob [`SS],
    input  rob_id_t   ent_rs2_rob [`SS],
    output rob_id_t   rob_next [`SS],
    output logic      out_valid,
    output rob_id_t   out_rob_id [`SS],
    output pc_t       out_pc [`SS],
    output arch_reg_t out_rd [`SS],
    output preg_t     out_rd_preg [`SS],
    output preg_t     out_rs1_preg [`SS],
    output preg_t     out_rs2_preg [`SS],
    output logic      out_rs1_ready [`SS],
    output logic      out_rs2_ready [`SS],
    output rob_id_t   out_rs1_rob [`SS],
    output rob_id_t   out_rs2_rob [`SS]
);
    rob_id_t rob_cnt;

    // Consecutive ids for the slots of the next bundle
    always_comb begin
        for (int i = 0; i < `SS; i++)
            rob_next[i] = rob_cnt + rob_id_t'(i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rob_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= dispatch;
            if (dispatch)
                rob_cnt <= rob_cnt + rob_id_t'(`SS);
        end
    end

    // Entry register, held until the next dispatch
    always_ff @(posedge clk) begin
        if (dispatch) begin
            out_rob_id    <= rob_next;
            out_pc        <= ent_pc;
            out_rd        <= ent_rd;
            out_rd_preg   <= ent_rd_preg;
            out_rs1_preg  <= ent_rs1_preg;
            out_rs2_preg  <= ent_rs2_preg;
            out_rs1_ready <= ent_rs1_ready;
            out_rs2_ready <= ent_rs2_ready;
            out_rs1_rob   <= ent_rs1_rob;
            out_rs2_rob   <= ent_rs2_rob;
        end
    end

endmodule

//--- src/dispatcher.sv
// Purely combinational; entry outputs are only meaningful while dispatch is high
`timescale 1ns/1ns
`include "rename_params.svh"

module dispatcher
    import rename_pkg::*;
(
    input  pc_t        head_pc [`SS],
    input  arch_reg_t  head_rs1 [`SS],
    input  arch_reg_t  head_rs2 [`SS],
    input  arch_reg_t  head_rd [`SS],
    input  logic       head_imm1 [`SS],
    input  logic       head_imm2 [`SS],
    input  logic       empty,
    input  logic       rs_full,
    output logic       pop,
    input  preg_t      fl_head [`SS],
    input  fl_count_t  fl_count,
    output logic [1:0] pop_cnt,
    input  rob_id_t    rob_next [`SS],
    rename_if.dispatch_mp ren,
    output logic       dispatch,
    output pc_t        ent_pc [`SS],
    output arch_reg_t  ent_rd [`SS],
    output preg_t      ent_rd_preg [`SS],
    output preg_t      ent_rs1_preg [`SS],
    output preg_t      ent_rs2_preg [`SS],
    output logic       ent_rs1_ready [`SS],
    output logic       ent_rs2_ready [`SS],
    output rob_id_t    ent_rs1_rob [`SS],
    output rob_id_t    ent_rs2_rob [`SS]
);
    fl_count_t need;
    preg_t     rd_preg [`SS];

    // Free registers needed, x0 destinations take none
    always_comb begin
        need = '0;
        for (int i = 0; i < `SS; i++)
            if (head_rd[i] != '0)
                need = need + fl_count_t'(1);
    end

    assign dispatch = !empty && !rs_full && (fl_count >= need);
    assign pop      = dispatch;
    assign pop_cnt  = dispatch ? need[1:0] : 2'd0;

    // Steer free heads in order to the renaming slots
    always_comb begin
        int k;
        k = 0;
        for (int i = 0; i < `SS; i++) begin
            ren.isa_rs1[i]   = head_rs1[i];
            ren.isa_rs2[i]   = head_rs2[i];
            ren.isa_rd[i]    = head_rd[i];
            ren.alloc_rob[i] = rob_next[i];
            ren.rd_we[i]     = dispatch && (head_rd[i] != '0);
            if (head_rd[i] != '0) begin
                rd_preg[i] = fl_head[k];
                k = k + 1;
            end else begin
                rd_preg[i] = '0;
            end
            ren.new_preg[i] = rd_preg[i];
        end
    end

    // Source operands with forwarding from older slots of the same bundle
    always_comb begin
        for (int i = 0; i < `SS; i++) begin
            ent_pc[i]        = head_pc[i];
            ent_rd[i]        = head_rd[i];
            ent_rd_preg[i]   = rd_preg[i];
            ent_rs1_preg[i]  = ren.map_rs1[i];
            ent_rs2_preg[i]  = ren.map_rs2[i];
            ent_rs1_ready[i] = !ren.busy1[i];
            ent_rs2_ready[i] = !ren.busy2[i];
            ent_rs1_rob[i]   = ren.src_rob1[i];
            ent_rs2_rob[i]   = ren.src_rob2[i];
            // Youngest older writer wins, its result is never ready yet
            for (int j = 0; j < i; j++) begin
                if ((head_rd[j] != '0) && (head_rs1[i] == head_rd[j])) begin
                    ent_rs1_preg[i]  = rd_preg[j];
                    ent_rs1_ready[i] = 1'b0;
                    ent_rs1_rob[i]   = rob_next[j];
                end
                if ((head_rd[j] != '0) && (head_rs2[i] == head_rd[j])) begin
                    ent_rs2_preg[i]  = rd_preg[j];
                    ent_rs2_ready[i] = 1'b0;
                    ent_rs2_rob[i]   = rob_next[j];
                end
            end
            // Immediate operands need no producer
            ent_rs1_ready[i] = ent_rs1_ready[i] || head_imm1[i];
            ent_rs2_ready[i] = ent_rs2_ready[i] || head_imm2[i];
        end
    end

endmodule

//--- src/free_list.sv
// Starts with pregs ARCH_REGS..PREG_COUNT-1; pop_cnt must not exceed count, pushes must not overfill
`timescale 1ns/1ns
`include "rename_params.svh"

module free_list
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic [1:0] pop_cnt,
    output preg_t     head_preg [`SS],
    output fl_count_t count,
    input  logic      push,
    input  preg_t     push_preg
);
    localparam int PTR_W = $clog2(`PREG_COUNT);

    preg_t            fifo [`PREG_COUNT];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    // Oldest free registers, slot i sees entry rd_ptr+i
    always_comb begin
        for (int i = 0; i < `SS; i++)
            head_preg[i] = fifo[rd_ptr + PTR_W'(i)];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map owns the low pregs, so the rest start out free
            for (int i = 0; i < `PREG_COUNT - `ARCH_REGS; i++)
                fifo[i] <= preg_t'(i + `ARCH_REGS);
            rd_ptr <= '0;
            wr_ptr <= PTR_W'(`PREG_COUNT - `ARCH_REGS);
            count  <= fl_count_t'(`PREG_COUNT - `ARCH_REGS);
        end else begin
            if (push) begin
                fifo[wr_ptr] <= push_preg;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
            // Same-cycle push and pop net out in the count
            count  <= count + fl_count_t'(push) - fl_count_t'(pop_cnt);
        end
    end

endmodule

//--- src/inst_queue.sv
// Pushes while in_ready is low are dropped; pop must only be raised while empty is low
`timescale 1ns/1ns
`include "rename_params.svh"

module inst_queue
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  pc_t       in_pc [`SS],
    input  arch_reg_t in_rs1 [`SS],
    input  arch_reg_t in_rs2 [`SS],
    input  arch_reg_t in_rd [`SS],
    input  logic      in_imm1 [`SS],
    input  logic      in_imm2 [`SS],
    input  logic      pop,
    output logic      empty,
    output pc_t       head_pc [`SS],
    output arch_reg_t head_rs1 [`SS],
    output arch_reg_t head_rs2 [`SS],
    output arch_reg_t head_rd [`SS],
    output logic      head_imm1 [`SS],
    output logic      head_imm2 [`SS]
);
    localparam int PTR_W = $clog2(`IQ_DEPTH);

    // Bundle storage, one row per bundle
    pc_t       q_pc [`IQ_DEPTH][`SS];
    arch_reg_t q_rs1 [`IQ_DEPTH][`SS];
    arch_reg_t q_rs2 [`IQ_DEPTH][`SS];
    arch_reg_t q_rd [`IQ_DEPTH][`SS];
    logic      q_imm1 [`IQ_DEPTH][`SS];
    logic      q_imm2 [`IQ_DEPTH][`SS];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             push;

    assign in_ready = (count != (PTR_W+1)'(`IQ_DEPTH));
    assign empty    = (count == '0);
    assign push     = in_valid && in_ready;

    // Head bundle is visible without a read cycle
    always_comb begin
        for (int i = 0; i < `SS; i++) begin
            head_pc[i]   = q_pc[rd_ptr][i];
            head_rs1[i]  = q_rs1[rd_ptr][i];
            head_rs2[i]  = q_rs2[rd_ptr][i];
            head_rd[i]   = q_rd[rd_ptr][i];
            head_imm1[i] = q_imm1[rd_ptr][i];
            head_imm2[i] = q_imm2[rd_ptr][i];
        end
    end

    // Payload write, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[wr_ptr]   <= in_pc;
            q_rs1[wr_ptr]  <= in_rs1;
            q_rs2[wr_ptr]  <= in_rs2;
            q_rd[wr_ptr]   <= in_rd;
            q_imm1[wr_ptr] <= in_imm1;
            q_imm2[wr_ptr] <= in_imm2;
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

endmodule

//--- src/rename_dispatch_top.sv
// Writebacks and retires come from outside; out_* are valid only in the out_valid cycle
`timescale 1ns/1ns
`include "rename_params.svh"

module rename_dispatch_top
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  pc_t       in_pc [`SS],
    input  arch_reg_t in_rs1 [`SS],
    input  arch_reg_t in_rs2 [`SS],
    input  arch_reg_t in_rd [`SS],
    input  logic      in_imm1 [`SS],
    input  logic      in_imm2 [`SS],
    input  logic      rs_full,
    input  logic      wb_valid,
    input  preg_t     wb_preg,
    input  logic      free_valid,
    input  preg_t     free_preg,
    output logic      out_valid,
    output rob_id_t   out_rob_id [`SS],
    output pc_t       out_pc [`SS],
    output arch_reg_t out_rd [`SS],
    output preg_t     out_rd_preg [`SS],
    output preg_t     out_rs1_preg [`SS],
    output preg_t     out_rs2_preg [`SS],
    output logic      out_rs1_ready [`SS],
    output logic      out_rs2_ready [`SS],
    output rob_id_t   out_rs1_rob [`SS],
    output rob_id_t   out_rs2_rob [`SS]
);
    // Queue head
    pc_t       head_pc [`SS];
    arch_reg_t head_rs1 [`SS];
    arch_reg_t head_rs2 [`SS];
    arch_reg_t head_rd [`SS];
    logic      head_imm1 [`SS];
    logic      head_imm2 [`SS];
    logic      empty;
    logic      pop;

    // Free list
    preg_t      fl_head [`SS];
    fl_count_t  fl_count;
    logic [1:0] pop_cnt;

    // Dispatch entry
    rob_id_t   rob_next [`SS];
    logic      dispatch;
    pc_t       ent_pc [`SS];
    arch_reg_t ent_rd [`SS];
    preg_t     ent_rd_preg [`SS];
    preg_t     ent_rs1_preg [`SS];
    preg_t     ent_rs2_preg [`SS];
    logic      ent_rs1_ready [`SS];
    logic      ent_rs2_ready [`SS];
    rob_id_t   ent_rs1_rob [`SS];
    rob_id_t   ent_rs2_rob [`SS];

    rename_if ren ();

    inst_queue u_iq (
        .clk, .rst, .in_valid, .in_ready, .in_pc, .in_rs1, .in_rs2, .in_rd,
        .in_imm1, .in_imm2, .pop, .empty, .head_pc, .head_rs1, .head_rs2,
        .head_rd, .head_imm1, .head_imm2
    );

    free_list u_fl (
        .clk, .rst, .pop_cnt, .head_preg(fl_head), .count(fl_count),
        .push(free_valid), .push_preg(free_preg)
    );

    rename_table u_rat (
        .clk, .rst, .ren(ren.table_mp), .wb_valid, .wb_preg
    );

    dispatcher u_disp (
        .head_pc, .head_rs1, .head_rs2, .head_rd, .head_imm1, .head_imm2,
        .empty, .rs_full, .pop, .fl_head, .fl_count, .pop_cnt, .rob_next,
        .ren(ren.dispatch_mp), .dispatch, .ent_pc, .ent_rd, .ent_rd_preg,
        .ent_rs1_preg, .ent_rs2_preg, .ent_rs1_ready, .ent_rs2_ready,
        .ent_rs1_rob, .ent_rs2_rob
    );

    dispatch_out u_out (
        .clk, .rst, .dispatch, .ent_pc, .ent_rd, .ent_rd_preg, .ent_rs1_preg,
        .ent_rs2_preg, .ent_rs1_ready, .ent_rs2_ready, .ent_rs1_rob, .ent_rs2_rob,
        .rob_next, .out_valid, .out_rob_id, .out_pc, .out_rd, .out_rd_preg,
        .out_rs1_preg, .out_rs2_preg, .out_rs1_ready, .out_rs2_ready,
        .out_rs1_rob, .out_rs2_rob
    );

endmodule

//--- src/rename_if.sv
// Reads are combinational; rd_we slots write the table at the next clock edge
`timescale 1ns/1ns
`include "rename_params.svh"

interface rename_if
    import rename_pkg::*;
();
    // Lookup and update requests from the dispatcher
    arch_reg_t isa_rs1 [`SS];
    arch_reg_t isa_rs2 [`SS];
    arch_reg_t isa_rd [`SS];
    logic      rd_we [`SS];
    preg_t     new_preg [`SS];
    rob_id_t   alloc_rob [`SS];

    // Mapping, busy state and producer tag from the table
    preg_t     map_rs1 [`SS];
    preg_t     map_rs2 [`SS];
    logic      busy1 [`SS];
    logic      busy2 [`SS];
    rob_id_t   src_rob1 [`SS];
    rob_id_t   src_rob2 [`SS];

    modport dispatch_mp (
        output isa_rs1, isa_rs2, isa_rd, rd_we, new_preg, alloc_rob,
        input  map_rs1, map_rs2, busy1, busy2, src_rob1, src_rob2
    );

    modport table_mp (
        input  isa_rs1, isa_rs2, isa_rd, rd_we, new_preg, alloc_rob,
        output map_rs1, map_rs2, busy1, busy2, src_rob1, src_rob2
    );

endinterface

//--- src/rename_params.svh
// Sizes are fixed for a two-wide core; ARCH_REGS must stay a power of two below PREG_COUNT
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Dispatch width
`define SS 2
// Architectural and physical register counts
`define ARCH_REGS 32
`define PREG_COUNT 64
// Reorder buffer entries
`define ROB_DEPTH 8
// Bundles held by the instruction queue
`define IQ_DEPTH 4

`endif

//--- src/rename_pkg.sv
// Widths follow rename_params.svh; fl_count_t needs one bit more than preg_t to hold a full list
`include "rename_params.svh"

package rename_pkg;

    // Architectural register number, x0 to x31
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // Physical register number
    typedef logic [$clog2(`PREG_COUNT)-1:0] preg_t;

    // ROB entry number
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    // Program counter
    typedef logic [31:0] pc_t;

    // Free list occupancy, 0 up to PREG_COUNT
    typedef logic [$clog2(`PREG_COUNT+1)-1:0] fl_count_t;

endpackage

//--- src/rename_table.sv
// No checkpointing; a busy bit stays set until its preg is written back
`timescale 1ns/1ns
`include "rename_params.svh"

module rename_table
    import rename_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    rename_if.table_mp ren,
    input  logic       wb_valid,
    input  preg_t      wb_preg
);
    preg_t   rat [`ARCH_REGS];
    logic    busy [`PREG_COUNT];
    // Producer tag per physical register
    rob_id_t prod_rob [`PREG_COUNT];

    // Combinational lookup with writeback bypass on the busy bits
    always_comb begin
        for (int i = 0; i < `SS; i++) begin
            ren.map_rs1[i]  = rat[ren.isa_rs1[i]];
            ren.map_rs2[i]  = rat[ren.isa_rs2[i]];
            ren.busy1[i]    = busy[ren.map_rs1[i]] &&
                              !(wb_valid && (wb_preg == ren.map_rs1[i]));
            ren.busy2[i]    = busy[ren.map_rs2[i]] &&
                              !(wb_valid && (wb_preg == ren.map_rs2[i]));
            ren.src_rob1[i] = prod_rob[ren.map_rs1[i]];
            ren.src_rob2[i] = prod_rob[ren.map_rs2[i]];
        end
    end

    // Map and busy update
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ARCH_REGS; r++)
                rat[r] <= preg_t'(r);
            for (int p = 0; p < `PREG_COUNT; p++)
                busy[p] <= 1'b0;
        end else begin
            if (wb_valid)
                busy[wb_preg] <= 1'b0;
            // Later slot overwrites an earlier one with the same rd
            for (int i = 0; i < `SS; i++) begin
                if (ren.rd_we[i]) begin
                    rat[ren.isa_rd[i]]   <= ren.new_preg[i];
                    busy[ren.new_preg[i]] <= 1'b1;
                end
            end
        end
    end

    // Tag written alongside the busy bit
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SS; i++) begin
            if (ren.rd_we[i])
                prod_rob[ren.new_preg[i]] <= ren.alloc_rob[i];
        end
    end

endmodule
